// File: build.f
led_pkg.sv
led_cmd_if.sv
led_color_if.sv
apb_cmd_stage.sv
color_regfile.sv
pwm_stage.sv
rgb_led_top.sv
tb_rgb_led.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rgb_led
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rgb_led.sv
module tb_rgb_led import led_pkg::*; ();

    localparam int CLK_HALF  = 20;
    localparam int DRIVE_DLY = 2;
    localparam int SETTLE    = 512;
    localparam int WINDOW    = 256;
    // three 768-cycle duty windows dominate the expected 2500 cycles
    localparam int MAX_CYCLES = 20000;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic [NUM_CH-1:0] led_r;
    logic [NUM_CH-1:0] led_g;
    logic [NUM_CH-1:0] led_b;

    // expected state kept by the testbench
    rgb_t       exp_rgb [NUM_CH];
    logic [1:0] exp_idx [NUM_CH];
    rgb_t       preset [NUM_CH];
    int         cycle_cnt = 0;
    // access cycles of the last apb transfer, pready cycle included
    int         access_cycles;

    rgb_led_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .led_r   (led_r),
        .led_g   (led_g),
        .led_b   (led_b)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    // setup cycle, then access cycles until pready at the falling edge
    task automatic apb_access(input logic wr, input logic [3:0] code,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {code, 2'b00};
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        access_cycles = 1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
            access_cycles++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] code, input logic [DATA_W-1:0] data,
                             output logic err);
        logic [DATA_W-1:0] unused;
        apb_access(1'b1, code, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] code, output logic [DATA_W-1:0] data,
                            output logic err);
        apb_access(1'b0, code, '0, data, err);
    endtask

    task automatic compare_channels(input string name);
        logic [DATA_W-1:0] rdata;
        logic              err;
        for (int n = 0; n < NUM_CH; n++) begin
            apb_read(REG_RD_BASE + 4'(n), rdata, err);
            check($sformatf("%s ch%0d access cycles", name, n), 32'd1, 32'(access_cycles));
            check($sformatf("%s ch%0d error", name, n), 32'd0, 32'(err));
            check($sformatf("%s ch%0d colour", name, n), 32'(exp_rgb[n]), rdata);
        end
    endtask

    // field 0 is the red high nibble, bits 23 to 20
    task automatic write_nibble(input string name, input logic [1:0] ch,
                                input int field, input logic [3:0] nib);
        logic err;
        apb_write(REG_NIB_FIRST + 4'(field), {26'd0, ch, nib}, err);
        check({name, " access cycles"}, 32'd2, 32'(access_cycles));
        check({name, " write error"}, 32'd0, 32'(err));
        exp_rgb[ch][(5 - field) * 4 +: 4] = nib;
    endtask

    task automatic step_preset(input string name, input logic [1:0] ch);
        logic err;
        apb_write(REG_NEXT, {26'd0, ch, 4'd0}, err);
        check({name, " access cycles"}, 32'd2, 32'(access_cycles));
        check({name, " write error"}, 32'd0, 32'(err));
        exp_idx[ch] = exp_idx[ch] + 2'd1;
        exp_rgb[ch] = preset[exp_idx[ch]];
    endtask

    task automatic measure_duty(input int ch, input int sel, output int high);
        high = 0;
        // long enough for any pending latch at the wrap
        repeat (SETTLE) @(posedge clk);
        repeat (WINDOW) begin
            @(negedge clk);
            if ((sel == 0 && led_r[ch]) || (sel == 1 && led_g[ch]) ||
                (sel == 2 && led_b[ch])) begin
                high++;
            end
        end
    endtask

    task automatic reset_colors();
        compare_channels("reset colours");
    endtask

    task automatic nibble_writes();
        logic [1:0] ch;
        logic [3:0] nib;
        ch = 2'($urandom());
        for (int f = 0; f < 6; f++) begin
            nib = 4'($urandom());
            write_nibble("nibble writes", ch, f, nib);
        end
        compare_channels("nibble writes");
    endtask

    task automatic preset_stepping();
        step_preset("next ch3", 2'd3);
        compare_channels("next ch3 first");
        step_preset("next ch3", 2'd3);
        compare_channels("next ch3 second");
        step_preset("next ch0", 2'd0);
        compare_channels("next ch0");
    endtask

    task automatic preset_reload();
        logic err;
        apb_write(REG_LOAD, '0, err);
        check("reload access cycles", 32'd2, 32'(access_cycles));
        check("reload write error", 32'd0, 32'(err));
        for (int n = 0; n < NUM_CH; n++) begin
            exp_rgb[n] = preset[n];
        end
        compare_channels("reload");
        // index of ch3 survives the reload
        step_preset("next after reload", 2'd3);
        compare_channels("next after reload");
    endtask

    task automatic pwm_duty();
        logic [3:0] nibs [6];
        int         high;
        nibs = '{4'h4, 4'h0, 4'h8, 4'h0, 4'hF, 4'hF};
        for (int f = 0; f < 6; f++) begin
            write_nibble("pwm colour", 2'd1, f, nibs[f]);
        end
        compare_channels("pwm colour");
        measure_duty(1, 0, high);
        check("pwm duty red", 32'(exp_rgb[1][23:16]), 32'(high));
        measure_duty(1, 1, high);
        check("pwm duty green", 32'(exp_rgb[1][15:8]), 32'(high));
        measure_duty(1, 2, high);
        check("pwm duty blue", 32'(exp_rgb[1][7:0]), 32'(high));
    endtask

    task automatic illegal_access();
        logic [DATA_W-1:0] rdata;
        logic              err;
        apb_write(4'd1, 32'h0000_003F, err);
        check("write code 1 access cycles", 32'd1, 32'(access_cycles));
        check("write code 1 error", 32'd1, 32'(err));
        apb_write(4'd12, 32'h0000_0015, err);
        check("write code 12 access cycles", 32'd1, 32'(access_cycles));
        check("write code 12 error", 32'd1, 32'(err));
        apb_read(4'd3, rdata, err);
        check("read code 3 access cycles", 32'd1, 32'(access_cycles));
        check("read code 3 error", 32'd1, 32'(err));
        compare_channels("after errors");
    endtask

    initial begin
        void'($urandom(32'h186));
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        preset[0] = PRESET_RED;
        preset[1] = PRESET_GREEN;
        preset[2] = PRESET_BLUE;
        preset[3] = PRESET_YELLOW;
        for (int n = 0; n < NUM_CH; n++) begin
            exp_rgb[n] = preset[n];
            exp_idx[n] = 2'(n);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        reset_colors();
        nibble_writes();
        preset_stepping();
        preset_reload();
        pwm_duty();
        illegal_access();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: rgb_led_top.sv
module rgb_led_top import led_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic [NUM_CH-1:0] led_r,
    output logic [NUM_CH-1:0] led_g,
    output logic [NUM_CH-1:0] led_b
);

    led_cmd_if   cmd_if ();
    led_color_if color_if ();

    apb_cmd_stage apb_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd_if.master),
        .color   (color_if.reader)
    );

    color_regfile regfile_i (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd_if.slave),
        .color (color_if.source)
    );

    // pwm reads the same colour array as the apb read path
    pwm_stage pwm_i (
        .clk   (clk),
        .rst   (rst),
        .color (color_if.reader),
        .led_r (led_r),
        .led_g (led_g),
        .led_b (led_b)
    );

endmodule

// File: pwm_stage.sv
module pwm_stage import led_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    led_color_if.reader       color,
    output logic [NUM_CH-1:0] led_r,
    output logic [NUM_CH-1:0] led_g,
    output logic [NUM_CH-1:0] led_b
);

    logic [PWM_W-1:0] cnt_q;
    rgb_t             lat_q [NUM_CH];
    logic             pend_q;
    logic             wrap;

    assign wrap = (cnt_q == '1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q  <= '0;
            pend_q <= 1'b0;
            lat_q  <= PRESET_TAB;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            // new colours only take effect at a period boundary
            if (wrap && (pend_q || color.update)) begin
                lat_q  <= color.rgb;
                pend_q <= 1'b0;
            end else if (color.update) begin
                pend_q <= 1'b1;
            end
        end
    end

    // registered compare, so the outputs are low out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_r <= '0;
            led_g <= '0;
            led_b <= '0;
        end else begin
            for (int n = 0; n < NUM_CH; n++) begin
                led_r[n] <= cnt_q < lat_q[n][2*PWM_W +: PWM_W];
                led_g[n] <= cnt_q < lat_q[n][PWM_W +: PWM_W];
                led_b[n] <= cnt_q < lat_q[n][0 +: PWM_W];
            end
        end
    end

endmodule

// File: color_regfile.sv
module color_regfile import led_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    led_cmd_if.slave    cmd,
    led_color_if.source color
);

    rgb_t            rgb_q [NUM_CH];
    logic [1:0]      idx_q [NUM_CH];
    logic            ack_q;
    logic            upd_q;
    logic            accept;
    logic [4:0]      nib_lsb;
    logic [1:0]      next_idx;

    // valid is still high in the ack cycle, so skip it there
    assign accept = cmd.valid & ~ack_q;

    // field 0 is the red high nibble at the top of the word
    assign nib_lsb = 5'(NUM_NIB - 1 - int'(cmd.field)) << 2;

    // 2-bit index wraps from 3 to 0 on its own
    assign next_idx = idx_q[cmd.channel] + 2'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_q <= PRESET_TAB;
            for (int n = 0; n < NUM_CH; n++) begin
                idx_q[n] <= 2'(n);
            end
            ack_q <= 1'b0;
            upd_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            upd_q <= 1'b0;
            if (accept) begin
                ack_q <= 1'b1;
                upd_q <= 1'b1;
                unique case (cmd.op)
                    op_load: begin
                        // indices are left as they are
                        rgb_q <= PRESET_TAB;
                    end
                    op_nibble: begin
                        rgb_q[cmd.channel][nib_lsb +: NIB_W] <= cmd.data;
                    end
                    op_next: begin
                        idx_q[cmd.channel] <= next_idx;
                        rgb_q[cmd.channel] <= PRESET_TAB[next_idx];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cmd.ack      = ack_q;
    assign color.rgb    = rgb_q;
    assign color.update = upd_q;

endmodule

// File: apb_cmd_stage.sv
module apb_cmd_stage import led_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    led_cmd_if.master         cmd,
    led_color_if.reader       color
);

    logic [3:0]      code;
    logic            access;
    logic            is_nib;
    logic            is_cmd_code;
    logic            is_rd_code;
    logic            cmd_wr;
    logic            rd_ok;
    logic            issued_q;
    logic [CH_W-1:0] rd_ch;

    assign code   = paddr[5:2];
    assign access = psel & penable;

    assign is_nib      = (code >= REG_NIB_FIRST) &&
                         (int'(code) < int'(REG_NIB_FIRST) + NUM_NIB);
    assign is_cmd_code = (code == REG_LOAD) || (code == REG_NEXT) || is_nib;
    assign is_rd_code  = (code >= REG_RD_BASE) &&
                         (int'(code) < int'(REG_RD_BASE) + NUM_CH);

    assign cmd_wr = pwrite & is_cmd_code;
    assign rd_ok  = ~pwrite & is_rd_code;

    // command fields
    always_comb begin
        if (code == REG_LOAD) begin
            cmd.op = op_load;
        end else if (code == REG_NEXT) begin
            cmd.op = op_next;
        end else begin
            cmd.op = op_nibble;
        end
    end

    assign cmd.field   = 3'(code - REG_NIB_FIRST);
    assign cmd.channel = pwdata[5:4];
    assign cmd.data    = pwdata[3:0];
    assign cmd.valid   = access & cmd_wr & ~issued_q;

    // stays set until the access phase ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issued_q <= 1'b0;
        end else if (!access) begin
            issued_q <= 1'b0;
        end else if (cmd.valid) begin
            issued_q <= 1'b1;
        end
    end

    // reads and errors finish in the first access cycle
    assign pready  = access & (~cmd_wr | cmd.ack);
    assign pslverr = access & ~(cmd_wr | rd_ok);

    assign rd_ch  = CH_W'(code - REG_RD_BASE);
    assign prdata = (access && rd_ok) ? DATA_W'(color.rgb[rd_ch]) : '0;

endmodule

// File: led_color_if.sv
interface led_color_if import led_pkg::*; ();

    rgb_t rgb [NUM_CH];
    // one cycle after any colour changes
    logic update;

    modport source (
        output rgb,
        output update
    );

    modport reader (
        input rgb,
        input update
    );

endinterface

// File: led_cmd_if.sv
interface led_cmd_if import led_pkg::*; ();

    logic            valid;
    led_op_e         op;
    logic [2:0]      field;
    logic [CH_W-1:0] channel;
    logic [NIB_W-1:0] data;
    logic            ack;

    // payload held stable while valid, until ack
    modport master (
        output valid, op, field, channel, data,
        input  ack
    );

    modport slave (
        input  valid, op, field, channel, data,
        output ack
    );

endinterface

// File: led_pkg.sv
package led_pkg;

    localparam int NUM_CH  = 4;
    localparam int CH_W    = $clog2(NUM_CH);
    localparam int COLOR_W = 24;
    localparam int PWM_W   = 8;
    localparam int NIB_W   = 4;
    localparam int NUM_NIB = COLOR_W / NIB_W;
    localparam int ADDR_W  = 6;
    localparam int DATA_W  = 32;

    // register codes, taken from paddr[5:2]
    localparam logic [3:0] REG_LOAD      = 4'd0;
    localparam logic [3:0] REG_NIB_FIRST = 4'd3;
    localparam logic [3:0] REG_NEXT      = 4'd9;
    localparam logic [3:0] REG_RD_BASE   = 4'd12;

    // red high byte, green middle, blue low
    typedef logic [COLOR_W-1:0] rgb_t;

    typedef enum logic [1:0] {
        op_load,
        op_nibble,
        op_next
    } led_op_e;

    localparam rgb_t PRESET_RED    = 24'hFF0000;
    localparam rgb_t PRESET_GREEN  = 24'h00FF00;
    localparam rgb_t PRESET_BLUE   = 24'h0000FF;
    localparam rgb_t PRESET_YELLOW = 24'hFFFF00;

    // preset n is also the reset colour of channel n
    localparam rgb_t PRESET_TAB [NUM_CH] = '{
        PRESET_RED,
        PRESET_GREEN,
        PRESET_BLUE,
        PRESET_YELLOW
    };

endpackage
